/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module llq_tb -f sources.f

sim:
	verilator --binary --timing --assert --top-module llq_tb -f sources.f -Mdir obj_dir -o llq_sim
	./obj_dir/llq_sim | tee /dev/stderr | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

/* sources.f */
+incdir+src
src/llq_pkg.sv
src/llq_sram.sv
src/llq_free_pool.sv
src/llq_state_table.sv
src/llq_pipe.sv
src/llq_top.sv
tb/llq_assert.sv
tb/llq_tb.sv

/* src/llq_free_pool.sv */
// Slot allocator, hands out the lowest free slot every cycle
// Caller must not alloc when slot_avail is low; release of a free slot is not checked
`timescale 1ns/1ps
`include "llq_settings.svh"

module llq_free_pool (
  input  logic           clk,
  input  logic           rst,
  input  logic           alloc,
  input  logic           release_en,
  input  llq_pkg::slot_t release_slot,
  output llq_pkg::slot_t alloc_slot,
  output logic           slot_avail,
  output logic           full
);

  logic [`LLQ_NUM_SLOTS-1:0] used;      // One bit per allocated slot
  logic [`LLQ_NUM_SLOTS-1:0] used_nxt;

  // Lowest clear bit wins, scan from the top down
  always_comb
  begin
    alloc_slot = '0;
    for (int i = `LLQ_NUM_SLOTS - 1; i >= 0; i--)
    begin
      if (!used[i])
        alloc_slot = llq_pkg::slot_t'(i);
    end
  end

  assign slot_avail = ~(&used);  // At least one slot left

  // Alloc and release never name the same slot
  always_comb
  begin
    used_nxt = used;
    if (alloc)
      used_nxt[alloc_slot] = 1'b1;
    if (release_en)
      used_nxt[release_slot] = 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      used <= '0;
      full <= 1'b0;
    end
    else
    begin
      used <= used_nxt;
      full <= &used_nxt;  // Tracks used exactly
    end
  end

endmodule

/* src/llq_pipe.sv */
// Three-stage command pipe; s0 reads state, s1 hits the link RAM, s2 writes back
// One op per context in flight, a matching command waits until s2 has drained
`timescale 1ns/1ps
`include "llq_settings.svh"

module llq_pipe (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  logic                     cmd_push,
  input  llq_pkg::ctxt_t           cmd_ctxt,
  input  llq_pkg::word_t           cmd_data,
  input  logic                     busy,
  input  llq_pkg::slot_t           alloc_slot,
  input  logic                     slot_avail,
  output logic                     alloc,
  output logic                     release_en,
  output llq_pkg::slot_t           release_slot,
  output llq_pkg::ctxt_t           rd_ctxt,
  output logic                     rd_en,
  input  llq_pkg::qstate_t         rd_state,
  output logic                     wr_en,
  output llq_pkg::ctxt_t           wr_ctxt,
  output llq_pkg::qstate_t         wr_state,
  output logic                     lkup_valid,
  output logic                     lkup_rnw,
  output llq_pkg::slot_t           lkup_addr,
  output llq_pkg::word_t           lkup_data,
  output logic                     lkup_empty_fault,
  output logic [`LLQ_NUM_CTXT-1:0] empty
);

  llq_pkg::op_t     s0_op;
  llq_pkg::op_t     s1_op;
  llq_pkg::op_t     s2_op;
  logic             s0_valid;
  logic             s1_valid;
  logic             s2_valid;
  logic             hazard;        // Offered context already in flight
  logic             accept;
  logic             pop_hit;       // s2 pop on a non-empty queue
  logic             link_wr_en;
  logic             link_rd_en;
  llq_pkg::slot_t   link_wr_addr;
  llq_pkg::slot_t   link_rd_addr;
  llq_pkg::slot_t   link_rd_data;  // Next-oldest slot, valid in s2
  llq_pkg::qstate_t nxt_state;

  always_comb
  begin
    hazard = (s0_valid & (s0_op.ctxt == cmd_ctxt))
           | (s1_valid & (s1_op.ctxt == cmd_ctxt))
           | (s2_valid & (s2_op.ctxt == cmd_ctxt));
    cmd_ready = ~busy & ~hazard & (~cmd_push | slot_avail);
    accept    = cmd_valid & cmd_ready;
    alloc     = accept & cmd_push;  // Slot claimed at accept
  end

  // Stage valids, no back-pressure inside the pipe
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      s0_valid <= 1'b0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end
    else
    begin
      s0_valid <= accept;
      s1_valid <= s0_valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      s0_op.push  <= cmd_push;
      s0_op.ctxt  <= cmd_ctxt;
      s0_op.data  <= cmd_data;
      s0_op.slot  <= alloc_slot;
      s0_op.state <= '0;  // Not known until s1
    end
    if (s0_valid)
      s1_op <= s0_op;
    if (s1_valid)
      s2_op <= '{push: s1_op.push, ctxt: s1_op.ctxt, data: s1_op.data,
                 slot: s1_op.slot, state: rd_state};
  end

  assign rd_en   = s0_valid;
  assign rd_ctxt = s0_op.ctxt;

  // Push links new slot behind old head, pop fetches the link after tail
  always_comb
  begin
    link_wr_en   = s1_valid & s1_op.push & ~rd_state.empty;
    link_wr_addr = rd_state.head;
    link_rd_en   = s1_valid & ~s1_op.push & ~rd_state.empty;
    link_rd_addr = rd_state.tail;
  end

  llq_sram #(
    .W     ($bits(llq_pkg::slot_t)),
    .DEPTH (`LLQ_NUM_SLOTS)
  ) u_link_ram (
    .clk     (clk),
    .wr_en   (link_wr_en),
    .wr_addr (link_wr_addr),
    .wr_data (s1_op.slot),
    .rd_en   (link_rd_en),
    .rd_addr (link_rd_addr),
    .rd_data (link_rd_data)
  );

  // Queue update rules
  always_comb
  begin
    nxt_state = s2_op.state;
    pop_hit   = ~s2_op.push & ~s2_op.state.empty;
    if (s2_op.push)
    begin
      nxt_state.empty = 1'b0;
      nxt_state.head  = s2_op.slot;
      if (s2_op.state.empty)
        nxt_state.tail = s2_op.slot;  // First entry is both ends
    end
    else if (pop_hit)
    begin
      nxt_state.empty = (s2_op.state.head == s2_op.state.tail);  // Last one out
      nxt_state.tail  = link_rd_data;
    end
    // Pop on empty falls through unchanged
  end

  assign wr_en        = s2_valid;
  assign wr_ctxt      = s2_op.ctxt;
  assign wr_state     = nxt_state;
  assign release_en   = s2_valid & pop_hit;
  assign release_slot = s2_op.state.tail;  // Oldest slot goes back to pool

  always_ff @(posedge clk)
  begin
    if (rst)
      empty <= '1;
    else if (s2_valid)
      empty[s2_op.ctxt] <= nxt_state.empty;
  end

  // Registered lookup strobe, payload only loads with a valid op
  always_ff @(posedge clk)
  begin
    if (rst)
      lkup_valid <= 1'b0;
    else
      lkup_valid <= s2_valid;
    if (s2_valid)
    begin
      lkup_rnw         <= ~s2_op.push;
      lkup_addr        <= s2_op.push ? s2_op.slot : s2_op.state.tail;
      lkup_data        <= s2_op.data;
      lkup_empty_fault <= ~s2_op.push & s2_op.state.empty;
    end
  end

endmodule

/* src/llq_pkg.sv */
// Shared types for the queue controller
// Widths follow the macros in llq_settings.svh
`include "llq_settings.svh"

package llq_pkg;

  typedef logic [`LLQ_CTXT_W-1:0] ctxt_t;  // Queue index
  typedef logic [`LLQ_SLOT_W-1:0] slot_t;  // Slot address
  typedef logic [`LLQ_WORD_W-1:0] word_t;  // Lookup payload

  // One state table entry per context
  typedef struct packed {
    logic  empty;  // No slots held
    slot_t head;   // Newest slot
    slot_t tail;   // Oldest slot, next to pop
  } qstate_t;

  // Operation as it moves down s0..s2
  typedef struct packed {
    logic    push;   // Low for pop
    ctxt_t   ctxt;
    word_t   data;   // Push payload
    slot_t   slot;   // Slot taken at accept, pushes only
    qstate_t state;  // Filled in s1 from state table
  } op_t;

endpackage

/* src/llq_settings.svh */
// Sizes shared by the queue controller RTL and testbench
// Slot count is kept small so a short random run can fill the pool
`ifndef LLQ_SETTINGS_SVH
`define LLQ_SETTINGS_SVH

// Lookup data width
`define LLQ_WORD_W 32

// Independent queues, must be a power of two
`define LLQ_NUM_CTXT 4

// Shared storage slots, must be a power of two
`define LLQ_NUM_SLOTS 16

// Derived index widths
`define LLQ_CTXT_W $clog2(`LLQ_NUM_CTXT)
`define LLQ_SLOT_W $clog2(`LLQ_NUM_SLOTS)

`endif

/* src/llq_sram.sv */
// Simple dual-port RAM, one write and one read port on one clock
// Read data is registered; read of the address being written returns old data
`timescale 1ns/1ps

module llq_sram #(
  parameter int W     = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [W-1:0]             wr_data,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [W-1:0]             rd_data
);

  logic [W-1:0] mem [DEPTH];  // Storage array

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
    // Nonblocking read sees pre-write contents
    if (rd_en)
      rd_data <= mem[rd_addr];  // Holds when not enabled
  end

endmodule

/* src/llq_state_table.sv */
// Per-context head/tail/empty table with a post-reset init sweep
// busy stays high through reset and for one cycle per context afterwards
`timescale 1ns/1ps
`include "llq_settings.svh"

module llq_state_table (
  input  logic             clk,
  input  logic             rst,
  input  llq_pkg::ctxt_t   rd_ctxt,
  input  logic             rd_en,
  output llq_pkg::qstate_t rd_state,
  input  logic             wr_en,
  input  llq_pkg::ctxt_t   wr_ctxt,
  input  llq_pkg::qstate_t wr_state,
  output logic             busy
);

  typedef enum logic {
    ST_SWEEP,  // Writing empty entries
    ST_READY   // Pipe owns the write port
  } sweep_st_t;

  sweep_st_t        state;
  llq_pkg::ctxt_t   sweep_ctxt;  // Entry being cleared
  logic             ram_wr_en;
  llq_pkg::ctxt_t   ram_wr_addr;
  llq_pkg::qstate_t ram_wr_data;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= ST_SWEEP;
      sweep_ctxt <= '0;
    end
    else if (state == ST_SWEEP)
    begin
      sweep_ctxt <= sweep_ctxt + 1'b1;
      if (sweep_ctxt == llq_pkg::ctxt_t'(`LLQ_NUM_CTXT - 1))
        state <= ST_READY;  // Last entry written this edge
    end
  end

  assign busy = (state == ST_SWEEP);

  // Sweep takes the write port from the pipe
  always_comb
  begin
    ram_wr_en   = busy | wr_en;
    ram_wr_addr = busy ? sweep_ctxt : wr_ctxt;
    ram_wr_data = busy ? llq_pkg::qstate_t'{empty: 1'b1, head: '0, tail: '0} : wr_state;
  end

  llq_sram #(
    .W     ($bits(llq_pkg::qstate_t)),
    .DEPTH (`LLQ_NUM_CTXT)
  ) u_ram (
    .clk     (clk),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_ctxt),
    .rd_data (rd_state)
  );

endmodule

/* src/llq_top.sv */
// Linked-list queue controller, contexts share one slot pool
// Commands are refused while busy; lookups have no back-pressure
`timescale 1ns/1ps
`include "llq_settings.svh"

module llq_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  logic                     cmd_push,
  input  llq_pkg::ctxt_t           cmd_ctxt,
  input  llq_pkg::word_t           cmd_data,
  output logic                     lkup_valid,
  output logic                     lkup_rnw,
  output llq_pkg::slot_t           lkup_addr,
  output llq_pkg::word_t           lkup_data,
  output logic                     lkup_empty_fault,
  output logic                     full,
  output logic [`LLQ_NUM_CTXT-1:0] empty,
  output logic                     busy
);

  // Pool side
  logic             alloc;
  logic             slot_avail;
  logic             release_en;
  llq_pkg::slot_t   alloc_slot;
  llq_pkg::slot_t   release_slot;
  // State table side
  logic             rd_en;
  logic             wr_en;
  llq_pkg::ctxt_t   rd_ctxt;
  llq_pkg::ctxt_t   wr_ctxt;
  llq_pkg::qstate_t rd_state;
  llq_pkg::qstate_t wr_state;

  llq_free_pool u_free_pool (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc),
    .release_en   (release_en),
    .release_slot (release_slot),
    .alloc_slot   (alloc_slot),
    .slot_avail   (slot_avail),
    .full         (full)
  );

  llq_state_table u_state_table (
    .clk      (clk),
    .rst      (rst),
    .rd_ctxt  (rd_ctxt),
    .rd_en    (rd_en),
    .rd_state (rd_state),
    .wr_en    (wr_en),
    .wr_ctxt  (wr_ctxt),
    .wr_state (wr_state),
    .busy     (busy)
  );

  llq_pipe u_pipe (
    .clk              (clk),
    .rst              (rst),
    .cmd_valid        (cmd_valid),
    .cmd_ready        (cmd_ready),
    .cmd_push         (cmd_push),
    .cmd_ctxt         (cmd_ctxt),
    .cmd_data         (cmd_data),
    .busy             (busy),
    .alloc_slot       (alloc_slot),
    .slot_avail       (slot_avail),
    .alloc            (alloc),
    .release_en       (release_en),
    .release_slot     (release_slot),
    .rd_ctxt          (rd_ctxt),
    .rd_en            (rd_en),
    .rd_state         (rd_state),
    .wr_en            (wr_en),
    .wr_ctxt          (wr_ctxt),
    .wr_state         (wr_state),
    .lkup_valid       (lkup_valid),
    .lkup_rnw         (lkup_rnw),
    .lkup_addr        (lkup_addr),
    .lkup_data        (lkup_data),
    .lkup_empty_fault (lkup_empty_fault),
    .empty            (empty)
  );

endmodule

/* tb/llq_assert.sv */
// Protocol checks for the queue controller, bound into llq_top
// Checks start once rst is sampled low; failures also tally in fail_cnt
`timescale 1ns/1ps

module llq_assert (
  input logic clk,
  input logic rst,
  input logic busy,
  input logic cmd_valid,
  input logic cmd_ready,
  input logic cmd_push,
  input logic full,
  input logic lkup_valid
);

  int unsigned fail_cnt = 0;  // Read by the testbench

  // Sweep owns the state table, nothing may come out
  a_lkup_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !lkup_valid)
    else
    begin
      fail_cnt++;
      $error("lookup strobe while sweep busy");
    end

  a_ready_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !cmd_ready)
    else
    begin
      fail_cnt++;
      $error("cmd_ready high while sweep busy");
    end

  // Pool exhausted means no push may transfer
  a_push_full: assert property (@(posedge clk) disable iff (rst)
                                (cmd_valid && cmd_ready && cmd_push) |-> !full)
    else
    begin
      fail_cnt++;
      $error("push handshake while pool full");
    end

  a_lkup_rst: assert property (@(posedge clk) rst |=> !lkup_valid)  // Reset clears strobe
    else
    begin
      fail_cnt++;
      $error("lookup strobe during reset");
    end

endmodule

bind llq_top llq_assert u_assert (
  .clk        (clk),
  .rst        (rst),
  .busy       (busy),
  .cmd_valid  (cmd_valid),
  .cmd_ready  (cmd_ready),
  .cmd_push   (cmd_push),
  .full       (full),
  .lkup_valid (lkup_valid)
);

/* tb/llq_tb.sv */
// Random push/pop traffic against a per-context FIFO model of slot addresses
// Lookups are matched in acceptance order; every wait has its own timeout
`timescale 1ns/1ps
`include "llq_settings.svh"

module llq_tb;

  localparam int unsigned SEED       = 32'h42ad_a22e;
  localparam int          NUM_RANDOM = 400;
  localparam int          ACCEPT_TO  = 50;   // Cycles
  localparam int          DRAIN_TO   = 100;
  localparam int          NUM_CTXT   = `LLQ_NUM_CTXT;
  localparam int          NUM_SLOTS  = `LLQ_NUM_SLOTS;

  logic                 clk;
  logic                 rst;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 cmd_push;
  llq_pkg::ctxt_t       cmd_ctxt;
  llq_pkg::word_t       cmd_data;
  logic                 lkup_valid;
  logic                 lkup_rnw;
  llq_pkg::slot_t       lkup_addr;
  llq_pkg::word_t       lkup_data;
  logic                 lkup_empty_fault;
  logic                 full;
  logic [NUM_CTXT-1:0]  empty;
  logic                 busy;

  llq_pkg::op_t   acc_q [$];                      // Accepted, lookup pending
  llq_pkg::slot_t fifo_mem [NUM_CTXT][NUM_SLOTS]; // Model queues, circular
  int             fifo_rd [NUM_CTXT];
  int             fifo_cnt [NUM_CTXT];
  int             left [NUM_CTXT];
  logic           live [NUM_SLOTS];               // Slot held by some queue
  int             mismatch_errs = 0;
  int             other_errs = 0;
  int             total_errs;
  logic           push;
  llq_pkg::ctxt_t first_ctxt;
  int             waited;

  llq_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .cmd_valid        (cmd_valid),
    .cmd_ready        (cmd_ready),
    .cmd_push         (cmd_push),
    .cmd_ctxt         (cmd_ctxt),
    .cmd_data         (cmd_data),
    .lkup_valid       (lkup_valid),
    .lkup_rnw         (lkup_rnw),
    .lkup_addr        (lkup_addr),
    .lkup_data        (lkup_data),
    .lkup_empty_fault (lkup_empty_fault),
    .full             (full),
    .empty            (empty),
    .busy             (busy)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  task automatic check_logic(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      mismatch_errs++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_slot(input llq_pkg::slot_t got, input llq_pkg::slot_t exp,
                            input string what);
    if (got !== exp)
    begin
      mismatch_errs++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input llq_pkg::word_t got, input llq_pkg::word_t exp,
                            input string what);
    if (got !== exp)
    begin
      mismatch_errs++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("ERROR at %0t: timed out waiting for %s", $time, what);
    $display("TEST FAIL");
    $finish;
  endtask

  // Call at a falling edge; returns at the accepting rising edge
  task automatic send_cmd(input logic is_push, input llq_pkg::ctxt_t ctxt,
                          input llq_pkg::word_t data);
    llq_pkg::op_t rec;
    int           cnt;
    rec       = '0;
    rec.push  = is_push;
    rec.ctxt  = ctxt;
    rec.data  = data;
    cnt       = 0;
    cmd_valid = 1'b1;
    cmd_push  = is_push;
    cmd_ctxt  = ctxt;
    cmd_data  = data;
    @(posedge clk);
    while (!cmd_ready)  // Held steady until ready
    begin
      if (cnt > ACCEPT_TO)
        abort_on_timeout("command acceptance");
      cnt++;
      @(posedge clk);
    end
    acc_q.push_back(rec);
  endtask

  // Drop valid and let every accepted command come out
  task automatic drain;
    int cnt;
    cnt = 0;
    @(negedge clk);
    cmd_valid = 1'b0;
    while (acc_q.size() != 0)
    begin
      if (cnt > DRAIN_TO)
        abort_on_timeout("outstanding lookups");
      cnt++;
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_empty_vec;
    for (int c = 0; c < NUM_CTXT; c++)
      check_logic(empty[c], fifo_cnt[c] == 0, $sformatf("empty[%0d]", c));
  endtask

  // Oldest accepted command owns this lookup
  task automatic check_lookup;
    llq_pkg::op_t   op;
    llq_pkg::slot_t front;
    int             c;
    if (acc_q.size() == 0)
    begin
      other_errs++;
      $display("ERROR at %0t: lookup seen with no command outstanding", $time);
      return;
    end
    op = acc_q.pop_front();
    c  = int'(op.ctxt);
    check_logic(lkup_rnw, ~op.push, "lookup direction");
    if (op.push)
    begin
      check_logic(lkup_empty_fault, 1'b0, "fault on push");
      check_word(lkup_data, op.data, "push data");
      check_logic(live[lkup_addr], 1'b0, "push slot already live");
      fifo_mem[c][(fifo_rd[c] + fifo_cnt[c]) % NUM_SLOTS] = lkup_addr;
      fifo_cnt[c]++;
      live[lkup_addr] = 1'b1;
    end
    else if (fifo_cnt[c] == 0)
      check_logic(lkup_empty_fault, 1'b1, "fault on empty pop");
    else
    begin
      front = fifo_mem[c][fifo_rd[c]];
      check_logic(lkup_empty_fault, 1'b0, "fault on pop");
      check_slot(lkup_addr, front, "pop address");
      live[front] = 1'b0;  // Slot back in pool
      fifo_rd[c]  = (fifo_rd[c] + 1) % NUM_SLOTS;
      fifo_cnt[c]--;
    end
  endtask

  // Outputs are registered, mid-cycle sample is stable
  always @(negedge clk)
  begin
    if (!rst && lkup_valid)
      check_lookup();
  end

  initial
  begin
    void'($urandom(SEED));
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_push  = 1'b0;
    cmd_ctxt  = '0;
    cmd_data  = '0;
    for (int c = 0; c < NUM_CTXT; c++)
    begin
      fifo_rd[c]  = 0;
      fifo_cnt[c] = 0;
    end
    for (int s = 0; s < NUM_SLOTS; s++)
      live[s] = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    // Sweep runs right after reset
    check_logic(busy, 1'b1, "busy after reset");
    check_logic(cmd_ready, 1'b0, "cmd_ready during sweep");
    waited = 0;
    while (busy)
    begin
      if (waited > 2 * NUM_CTXT)
        abort_on_timeout("end of reset sweep");
      waited++;
      @(negedge clk);
    end
    check_empty_vec();  // Model is all empty here

    // Random traffic, about 60 percent pushes
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      @(negedge clk);
      if (($urandom % 4) == 0)
      begin
        cmd_valid = 1'b0;  // Idle gap
        @(negedge clk);
      end
      push = (($urandom % 10) < 6);
      if (full)
        push = 1'b0;  // Would block forever
      send_cmd(push, llq_pkg::ctxt_t'($urandom), llq_pkg::word_t'($urandom));
    end
    drain();
    check_empty_vec();

    // Empty every queue, then fill the pool
    for (int c = 0; c < NUM_CTXT; c++)
      left[c] = fifo_cnt[c];
    for (int c = 0; c < NUM_CTXT; c++)
    begin
      for (int k = 0; k < left[c]; k++)
      begin
        @(negedge clk);
        send_cmd(1'b0, llq_pkg::ctxt_t'(c), llq_pkg::word_t'($urandom));
      end
    end
    drain();
    check_logic(full, 1'b0, "full with empty pool");
    first_ctxt = llq_pkg::ctxt_t'($urandom);
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      @(negedge clk);
      send_cmd(1'b1, (k == 0) ? first_ctxt : llq_pkg::ctxt_t'($urandom),
               llq_pkg::word_t'($urandom));
    end
    drain();
    check_logic(full, 1'b1, "full after filling pool");

    // One more push must be refused
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_push  = 1'b1;
    cmd_ctxt  = first_ctxt;
    cmd_data  = llq_pkg::word_t'($urandom);
    repeat (20)
    begin
      @(posedge clk);
      if (cmd_ready)
      begin
        other_errs++;
        $display("ERROR at %0t: push offered ready while pool full", $time);
      end
    end
    drain();

    // A pop frees one slot for the push
    @(negedge clk);
    send_cmd(1'b0, first_ctxt, llq_pkg::word_t'($urandom));
    drain();
    check_logic(full, 1'b0, "full after one pop");
    @(negedge clk);
    send_cmd(1'b1, first_ctxt, llq_pkg::word_t'($urandom));
    drain();
    check_logic(full, 1'b1, "full after refill");
    check_empty_vec();

    total_errs = mismatch_errs + other_errs + int'(dut0.u_assert.fail_cnt);
    $display("Errors: %0d mismatch, %0d other, %0d assertion", mismatch_errs, other_errs,
             dut0.u_assert.fail_cnt);
    if (total_errs == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
